// ==== source/ssp21_pkg.sv ====
`default_nettype none

package ssp21_pkg;

	///////////////////////////////////////////////////////////////////////
	// SSP-21 message encodings

	// Function code in the first byte of every message
	typedef enum logic [7:0] {
		REQUEST_HANDSHAKE_BEGIN = 8'h00,
		REPLY_HANDSHAKE_BEGIN   = 8'h01,
		REPLY_HANDSHAKE_ERROR   = 8'h02
	} ssp21_function_t;

	// Error codes carried by Reply-Handshake-Error
	typedef enum logic [7:0] {
		BAD_MESSAGE_FORMAT              = 8'h00,
		UNSUPPORTED_HANDSHAKE_EPHEMERAL = 8'h02,
		UNSUPPORTED_HANDSHAKE_HASH      = 8'h03,
		UNSUPPORTED_HANDSHAKE_KDF       = 8'h04,
		UNSUPPORTED_NONCE_MODE          = 8'h06,
		UNSUPPORTED_HANDSHAKE_MODE      = 8'h07
	} ssp21_error_t;

	// Handshake modes, only one is configured at a time
	typedef enum logic [7:0] {
		SHARED_SECRET    = 8'h00,
		QUANTUM_KEY      = 8'h01,
		PRESHARED_PUBLIC = 8'h02
	} ssp21_handshake_mode_t;

	// Ephemeral data sent by the initiator
	typedef enum logic [7:0] {
		X25519 = 8'h00,
		NONCE  = 8'h01
	} ssp21_ephemeral_mode_t;

	// Only accepted value of each crypto spec field
	localparam logic [7:0] SSP21_HASH_SHA256             = 8'h00;
	localparam logic [7:0] SSP21_KDF_HKDF_SHA256         = 8'h00;
	localparam logic [7:0] SSP21_NONCE_INCREMENT_LAST_RX = 8'h00;

	// Ephemeral nonce length in bytes
	localparam logic [7:0] SSP21_NONCE_BYTES = 8'd32;

	///////////////////////////////////////////////////////////////////////
	// UDP socket

	localparam logic [15:0] SSP21_SERVER_PORT = 16'd8888;

	// Reply payload lengths
	localparam logic [15:0] ERROR_REPLY_LEN = 16'd2;
	localparam logic [15:0] ACK_REPLY_LEN   = 16'd4;

	///////////////////////////////////////////////////////////////////////
	// Register map

	localparam logic [3:0] CSR_MODE            = 4'h0;
	localparam logic [3:0] CSR_HANDSHAKE_COUNT = 4'h4;
	localparam logic [3:0] CSR_ERROR_COUNT     = 4'h8;
	localparam logic [3:0] CSR_LAST_ERROR      = 4'hC;

	// AXI response codes
	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== source/ssp21_rx_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module ssp21_rx_parser (
	input wire clk,
	input wire rst_n,
	input wire rx_start,
	input wire [31:0] rx_src_ip,
	input wire [15:0] rx_src_port,
	input wire [15:0] rx_dst_port,
	input wire rx_data_valid,
	input wire [31:0] rx_data,
	input wire [2:0] rx_bytes_valid,
	input wire rx_commit,
	input wire rx_drop,
	input wire ssp21_pkg::ssp21_handshake_mode_t cfg_mode,
	input wire reply_done,
	output logic reply_error_req,
	output logic reply_ack_req,
	output ssp21_pkg::ssp21_error_t reply_error_id,
	output ssp21_pkg::ssp21_ephemeral_mode_t reply_ephemeral,
	output logic [15:0] reply_max_nonce,
	output logic [31:0] reply_ip,
	output logic [15:0] reply_port
);

	typedef enum logic [2:0] {
		RX_IDLE, RX_FIRST, RX_SPEC, RX_CONSTRAINTS,
		RX_MODE, RX_NONCE, RX_WAIT_COMMIT, RX_REJECT
	} rx_state_t;

	rx_state_t state, state_nx;

	// Decision of the current cycle
	logic err_hit;
	logic ack_hit;
	ssp21_pkg::ssp21_error_t err_code;

	// Reply slot bookkeeping
	logic reply_busy;
	logic busy_now;
	logic issue;

	// Fields captured along the frame
	logic start_ok;
	logic [31:0] src_ip;
	logic [15:0] src_port;
	ssp21_pkg::ssp21_ephemeral_mode_t ephemeral;
	logic [15:0] max_nonce;
	logic [7:0] nonce_count;
	logic [7:0] nonce_sum;

	// New frame for our port, also allowed while flushing a rejected one
	assign start_ok = rx_start && (rx_dst_port == ssp21_pkg::SSP21_SERVER_PORT) &&
		(state == RX_IDLE || state == RX_REJECT);

	// Slot frees up in the same cycle the responder commits
	assign busy_now = reply_busy && !reply_done;
	assign issue = (err_hit || ack_hit) && !busy_now;

	assign nonce_sum = nonce_count + {5'd0, rx_bytes_valid};

	///////////////////////////////////////////////////////////////////////
	// Next state and reply decision

	always_comb begin
		state_nx = state;
		err_hit = 1'b0;
		ack_hit = 1'b0;
		err_code = ssp21_pkg::BAD_MESSAGE_FORMAT;
		case (state)
			RX_IDLE, RX_REJECT: begin
				if (start_ok)
					state_nx = RX_FIRST;
				// Rest of a rejected frame is swallowed
				else if (state == RX_REJECT && (rx_commit || rx_drop))
					state_nx = RX_IDLE;
			end
			RX_WAIT_COMMIT: begin
				// Trailing words are ignored here
				if (rx_drop) begin
					err_hit = 1'b1;
					state_nx = RX_IDLE;
				end else if (rx_commit) begin
					ack_hit = 1'b1;
					state_nx = RX_IDLE;
				end
			end
			default: begin
				// Frame ended early or failed its checksum
				if (rx_drop || rx_commit) begin
					err_hit = 1'b1;
					state_nx = RX_IDLE;
				end else if (rx_data_valid) begin
					// Header words must be full
					if (state != RX_NONCE && rx_bytes_valid != 3'd4) begin
						err_hit = 1'b1;
					end else begin
						case (state)
							RX_FIRST: begin
								if (rx_data[31:24] != ssp21_pkg::REQUEST_HANDSHAKE_BEGIN)
									err_hit = 1'b1;
								else
									state_nx = RX_SPEC;
							end
							// Hash, KDF, nonce mode, session mode
							RX_SPEC: begin
								err_hit = 1'b1;
								if (rx_data[31:24] != ssp21_pkg::SSP21_HASH_SHA256)
									err_code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_HASH;
								else if (rx_data[23:16] != ssp21_pkg::SSP21_KDF_HKDF_SHA256)
									err_code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_KDF;
								else if (rx_data[15:8] != ssp21_pkg::SSP21_NONCE_INCREMENT_LAST_RX)
									err_code = ssp21_pkg::UNSUPPORTED_NONCE_MODE;
								else begin
									err_hit = 1'b0;
									state_nx = RX_CONSTRAINTS;
								end
							end
							// Max nonce and upper session duration, nothing to check
							RX_CONSTRAINTS: state_nx = RX_MODE;
							// Lower session duration, handshake mode, ephemeral length
							RX_MODE: begin
								err_hit = 1'b1;
								if (rx_data[15:8] != cfg_mode)
									err_code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_MODE;
								else if (ephemeral != ssp21_pkg::NONCE)
									err_code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_EPHEMERAL;
								else if (rx_data[7:0] != ssp21_pkg::SSP21_NONCE_BYTES)
									err_code = ssp21_pkg::BAD_MESSAGE_FORMAT;
								else begin
									err_hit = 1'b0;
									state_nx = RX_NONCE;
								end
							end
							// Nonce may arrive in partial words
							RX_NONCE: begin
								if (nonce_sum >= ssp21_pkg::SSP21_NONCE_BYTES)
									state_nx = RX_WAIT_COMMIT;
							end
							default: state_nx = RX_IDLE;
						endcase
					end
					if (err_hit)
						state_nx = RX_REJECT;
				end
			end
		endcase
	end

	///////////////////////////////////////////////////////////////////////
	// Control registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			reply_error_req <= 1'b0;
			reply_ack_req <= 1'b0;
			reply_busy <= 1'b0;
			nonce_count <= 8'd0;
		end else begin
			state <= state_nx;
			// Overlapping replies are dropped without notice
			reply_error_req <= err_hit && !busy_now;
			reply_ack_req <= ack_hit && !busy_now;
			if (issue)
				reply_busy <= 1'b1;
			else if (reply_done)
				reply_busy <= 1'b0;
			if (state != RX_NONCE)
				nonce_count <= 8'd0;
			else if (rx_data_valid)
				nonce_count <= nonce_sum;
		end
	end

	// Captured fields and the reply hand-off
	always_ff @(posedge clk) begin
		if (start_ok) begin
			src_ip <= rx_src_ip;
			src_port <= rx_src_port;
		end
		if (state == RX_FIRST && rx_data_valid)
			ephemeral <= ssp21_pkg::ssp21_ephemeral_mode_t'(rx_data[7:0]);
		if (state == RX_CONSTRAINTS && rx_data_valid)
			max_nonce <= rx_data[31:16];
		if (issue) begin
			reply_error_id <= err_code;
			reply_ephemeral <= ephemeral;
			reply_max_nonce <= max_nonce;
			reply_ip <= src_ip;
			reply_port <= src_port;
		end
	end

endmodule

`default_nettype wire

// ==== source/ssp21_tx_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ssp21_tx_responder (
	input wire clk,
	input wire rst_n,
	input wire reply_error_req,
	input wire reply_ack_req,
	input wire ssp21_pkg::ssp21_error_t reply_error_id,
	input wire ssp21_pkg::ssp21_ephemeral_mode_t reply_ephemeral,
	input wire [15:0] reply_max_nonce,
	input wire [31:0] reply_ip,
	input wire [15:0] reply_port,
	output logic tx_start,
	output logic [31:0] tx_dst_ip,
	output logic [15:0] tx_dst_port,
	output logic [15:0] tx_src_port,
	output logic [15:0] tx_payload_len,
	output logic tx_data_valid,
	output logic [31:0] tx_data,
	output logic [2:0] tx_bytes_valid,
	output logic tx_commit,
	output logic tx_drop,
	output logic reply_done,
	output logic sent_ack,
	output logic sent_error,
	output ssp21_pkg::ssp21_error_t sent_error_id
);

	typedef enum logic [1:0] {
		TX_IDLE, TX_HEADER, TX_DATA, TX_COMMIT
	} tx_state_t;

	tx_state_t state;

	// Reply being sent
	logic accept;
	logic is_ack;
	ssp21_pkg::ssp21_error_t err_id;
	ssp21_pkg::ssp21_ephemeral_mode_t ephemeral;
	logic [15:0] max_nonce;

	// Error request wins if both ever show up together
	assign accept = (state == TX_IDLE) && (reply_error_req || reply_ack_req);

	// Replies always come from the server port
	assign tx_src_port = ssp21_pkg::SSP21_SERVER_PORT;

	// Every reply is complete, so a frame is never abandoned
	assign tx_drop = 1'b0;

	assign sent_error_id = err_id;

	///////////////////////////////////////////////////////////////////////
	// Frame sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			tx_start <= 1'b0;
			tx_data_valid <= 1'b0;
			tx_commit <= 1'b0;
			reply_done <= 1'b0;
			sent_ack <= 1'b0;
			sent_error <= 1'b0;
		end else begin
			// All stream strobes are single-cycle
			tx_start <= 1'b0;
			tx_data_valid <= 1'b0;
			tx_commit <= 1'b0;
			reply_done <= 1'b0;
			sent_ack <= 1'b0;
			sent_error <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (accept)
						state <= TX_HEADER;
				end
				TX_HEADER: begin
					tx_start <= 1'b1;
					state <= TX_DATA;
				end
				// Whole payload fits in one beat
				TX_DATA: begin
					tx_data_valid <= 1'b1;
					state <= TX_COMMIT;
				end
				TX_COMMIT: begin
					tx_commit <= 1'b1;
					reply_done <= 1'b1;
					sent_ack <= is_ack;
					sent_error <= !is_ack;
					state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	///////////////////////////////////////////////////////////////////////
	// Header and payload

	always_ff @(posedge clk) begin
		if (accept) begin
			is_ack <= !reply_error_req;
			err_id <= reply_error_id;
			ephemeral <= reply_ephemeral;
			max_nonce <= reply_max_nonce;
			// Send back to the requester
			tx_dst_ip <= reply_ip;
			tx_dst_port <= reply_port;
			tx_payload_len <= reply_error_req ? ssp21_pkg::ERROR_REPLY_LEN :
				ssp21_pkg::ACK_REPLY_LEN;
		end
		if (state == TX_DATA) begin
			if (is_ack) begin
				tx_data <= {ssp21_pkg::REPLY_HANDSHAKE_BEGIN, ephemeral, max_nonce};
				tx_bytes_valid <= 3'd4;
			end else begin
				tx_data <= {ssp21_pkg::REPLY_HANDSHAKE_ERROR, err_id, 16'h0000};
				tx_bytes_valid <= 3'd2;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/ssp21_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module ssp21_csr (
	input wire clk,
	input wire rst_n,
	input wire [3:0] s_axil_awaddr,
	input wire s_axil_awvalid,
	output logic s_axil_awready,
	input wire [31:0] s_axil_wdata,
	input wire [3:0] s_axil_wstrb,
	input wire s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input wire s_axil_bready,
	input wire [3:0] s_axil_araddr,
	input wire s_axil_arvalid,
	output logic s_axil_arready,
	output logic [31:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input wire s_axil_rready,
	input wire sent_ack,
	input wire sent_error,
	input wire ssp21_pkg::ssp21_error_t sent_error_id,
	output ssp21_pkg::ssp21_handshake_mode_t cfg_mode
);

	// Write address and data held until both are in
	logic aw_full;
	logic w_full;
	logic [3:0] aw_addr;
	logic [31:0] w_data;
	logic [3:0] w_strb;
	logic wr_go;

	// Status registers
	logic [31:0] handshake_count;
	logic [31:0] error_count;
	ssp21_pkg::ssp21_error_t last_error;

	// Read mux
	logic [31:0] rd_data;

	assign wr_go = aw_full && w_full && !s_axil_bvalid;

	always_comb begin
		case (s_axil_araddr)
			ssp21_pkg::CSR_MODE: rd_data = {24'd0, cfg_mode};
			ssp21_pkg::CSR_HANDSHAKE_COUNT: rd_data = handshake_count;
			ssp21_pkg::CSR_ERROR_COUNT: rd_data = error_count;
			ssp21_pkg::CSR_LAST_ERROR: rd_data = {24'd0, last_error};
			default: rd_data = 32'd0;
		endcase
	end

	///////////////////////////////////////////////////////////////////////
	// AXI4-Lite handshakes and registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s_axil_awready <= 1'b0;
			s_axil_wready <= 1'b0;
			s_axil_bvalid <= 1'b0;
			s_axil_bresp <= ssp21_pkg::AXI_RESP_OKAY;
			s_axil_arready <= 1'b0;
			s_axil_rvalid <= 1'b0;
			s_axil_rresp <= ssp21_pkg::AXI_RESP_OKAY;
			aw_full <= 1'b0;
			w_full <= 1'b0;
			cfg_mode <= ssp21_pkg::SHARED_SECRET;
			handshake_count <= 32'd0;
			error_count <= 32'd0;
			last_error <= ssp21_pkg::BAD_MESSAGE_FORMAT;
		end else begin
			// Ready pulses for one cycle per accepted beat
			s_axil_awready <= !s_axil_awready && s_axil_awvalid && !aw_full;
			s_axil_wready <= !s_axil_wready && s_axil_wvalid && !w_full;
			if (s_axil_awvalid && s_axil_awready)
				aw_full <= 1'b1;
			if (s_axil_wvalid && s_axil_wready)
				w_full <= 1'b1;
			if (s_axil_bvalid && s_axil_bready)
				s_axil_bvalid <= 1'b0;
			// Only MODE is writable, others answer OKAY and keep their value
			if (wr_go) begin
				aw_full <= 1'b0;
				w_full <= 1'b0;
				s_axil_bvalid <= 1'b1;
				s_axil_bresp <= (aw_addr[1:0] == 2'b00) ? ssp21_pkg::AXI_RESP_OKAY :
					ssp21_pkg::AXI_RESP_SLVERR;
				if (aw_addr == ssp21_pkg::CSR_MODE && w_strb[0])
					cfg_mode <= ssp21_pkg::ssp21_handshake_mode_t'(w_data[7:0]);
			end
			s_axil_arready <= !s_axil_arready && s_axil_arvalid && !s_axil_rvalid;
			if (s_axil_arvalid && s_axil_arready) begin
				s_axil_rvalid <= 1'b1;
				s_axil_rresp <= (s_axil_araddr[1:0] == 2'b00) ? ssp21_pkg::AXI_RESP_OKAY :
					ssp21_pkg::AXI_RESP_SLVERR;
			end else if (s_axil_rvalid && s_axil_rready) begin
				s_axil_rvalid <= 1'b0;
			end
			// Reply tallies, wrap on overflow
			if (sent_ack)
				handshake_count <= handshake_count + 32'd1;
			if (sent_error) begin
				error_count <= error_count + 32'd1;
				last_error <= sent_error_id;
			end
		end
	end

	// Captured write beat and read data
	always_ff @(posedge clk) begin
		if (s_axil_awvalid && s_axil_awready)
			aw_addr <= s_axil_awaddr;
		if (s_axil_wvalid && s_axil_wready) begin
			w_data <= s_axil_wdata;
			w_strb <= s_axil_wstrb;
		end
		if (s_axil_arvalid && s_axil_arready)
			s_axil_rdata <= rd_data;
	end

endmodule

`default_nettype wire

// ==== source/ssp21_udp_server.sv ====
`timescale 1ns/1ps
`default_nettype none

module ssp21_udp_server (
	input wire clk,
	input wire rst_n,
	// UDP receive stream
	input wire rx_start,
	input wire [31:0] rx_src_ip,
	input wire [15:0] rx_src_port,
	input wire [15:0] rx_dst_port,
	input wire rx_data_valid,
	input wire [31:0] rx_data,
	input wire [2:0] rx_bytes_valid,
	input wire rx_commit,
	input wire rx_drop,
	// UDP transmit stream
	output wire tx_start,
	output wire [31:0] tx_dst_ip,
	output wire [15:0] tx_dst_port,
	output wire [15:0] tx_src_port,
	output wire [15:0] tx_payload_len,
	output wire tx_data_valid,
	output wire [31:0] tx_data,
	output wire [2:0] tx_bytes_valid,
	output wire tx_commit,
	output wire tx_drop,
	// Register port
	input wire [3:0] s_axil_awaddr,
	input wire s_axil_awvalid,
	output wire s_axil_awready,
	input wire [31:0] s_axil_wdata,
	input wire [3:0] s_axil_wstrb,
	input wire s_axil_wvalid,
	output wire s_axil_wready,
	output wire [1:0] s_axil_bresp,
	output wire s_axil_bvalid,
	input wire s_axil_bready,
	input wire [3:0] s_axil_araddr,
	input wire s_axil_arvalid,
	output wire s_axil_arready,
	output wire [31:0] s_axil_rdata,
	output wire [1:0] s_axil_rresp,
	output wire s_axil_rvalid,
	input wire s_axil_rready
);

	// Parser to responder
	wire reply_error_req;
	wire reply_ack_req;
	wire ssp21_pkg::ssp21_error_t reply_error_id;
	wire ssp21_pkg::ssp21_ephemeral_mode_t reply_ephemeral;
	wire [15:0] reply_max_nonce;
	wire [31:0] reply_ip;
	wire [15:0] reply_port;
	wire reply_done;

	// Responder to registers, registers to parser
	wire sent_ack;
	wire sent_error;
	wire ssp21_pkg::ssp21_error_t sent_error_id;
	wire ssp21_pkg::ssp21_handshake_mode_t cfg_mode;

	ssp21_rx_parser u_rx_parser (.*);

	ssp21_tx_responder u_tx_responder (.*);

	ssp21_csr u_csr (.*);

endmodule

`default_nettype wire

// ==== verif/ssp21_udp_server_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ssp21_udp_server_properties (
	input wire clk,
	input wire rst_n,
	input wire tx_start,
	input wire tx_data_valid,
	input wire [2:0] tx_bytes_valid,
	input wire tx_commit,
	input wire s_axil_bvalid,
	input wire s_axil_bready,
	input wire s_axil_rvalid,
	input wire s_axil_rready
);

	///////////////////////////////////////////////////////////////////////
	// Transmit stream framing

	// Single data beat right after the header
	assert property (@(posedge clk) disable iff (!rst_n) tx_start |=> tx_data_valid)
		else $error("tx_data_valid did not follow tx_start");

	assert property (@(posedge clk) disable iff (!rst_n) tx_data_valid |=> tx_commit)
		else $error("tx_commit did not follow tx_data_valid");

	assert property (@(posedge clk) disable iff (!rst_n)
		tx_data_valid |-> (tx_bytes_valid >= 3'd1 && tx_bytes_valid <= 3'd4))
		else $error("tx_bytes_valid out of range");

	///////////////////////////////////////////////////////////////////////
	// AXI4-Lite response channels

	// Responses wait for the master
	assert property (@(posedge clk) disable iff (!rst_n)
		s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge clk) disable iff (!rst_n)
		s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
		else $error("rvalid dropped before rready");

endmodule

bind ssp21_udp_server ssp21_udp_server_properties u_properties (.*);

`default_nettype wire

// ==== verif/tb_ssp21_udp_server.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ssp21_udp_server;

	localparam int FRAME_COUNT = 14;
	localparam int CSR_ACCESSES = 8;
	localparam int WATCHDOG_CYCLES = FRAME_COUNT * 200 + CSR_ACCESSES * 50 + 20;

	logic clk;
	logic rst_n;
	logic rx_start;
	logic [31:0] rx_src_ip;
	logic [15:0] rx_src_port;
	logic [15:0] rx_dst_port;
	logic rx_data_valid;
	logic [31:0] rx_data;
	logic [2:0] rx_bytes_valid;
	logic rx_commit;
	logic rx_drop;
	wire tx_start;
	wire [31:0] tx_dst_ip;
	wire [15:0] tx_dst_port;
	wire [15:0] tx_src_port;
	wire [15:0] tx_payload_len;
	wire tx_data_valid;
	wire [31:0] tx_data;
	wire [2:0] tx_bytes_valid;
	wire tx_commit;
	wire tx_drop;
	logic [3:0] s_axil_awaddr;
	logic s_axil_awvalid;
	wire s_axil_awready;
	logic [31:0] s_axil_wdata;
	logic [3:0] s_axil_wstrb;
	logic s_axil_wvalid;
	wire s_axil_wready;
	wire [1:0] s_axil_bresp;
	wire s_axil_bvalid;
	logic s_axil_bready;
	logic [3:0] s_axil_araddr;
	logic s_axil_arvalid;
	wire s_axil_arready;
	wire [31:0] s_axil_rdata;
	wire [1:0] s_axil_rresp;
	wire s_axil_rvalid;
	logic s_axil_rready;

	// Frame under construction
	logic [31:0] fr_words[$];
	logic [2:0] fr_bytes[$];

	// Expected reply of the frame in flight
	bit exp_reply;
	bit exp_is_ack;
	ssp21_pkg::ssp21_error_t exp_err;
	int exp_cycle;
	logic [31:0] exp_ip;
	logic [15:0] exp_port;
	logic [15:0] exp_max_nonce;

	// Own tally of the replies
	int replies_seen;
	int tally_ack;
	int tally_err;
	ssp21_pkg::ssp21_error_t tally_last;
	ssp21_pkg::ssp21_handshake_mode_t tb_mode;

	logic [31:0] rng;
	int cyc;
	int errors;

	ssp21_udp_server u_ssp21_udp_server (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	///////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_run(input string msg);
		errors++;
		$display("Error: time %0t: %s", $time, msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("%s got 0x%0h expected 0x%0h", what, got, exp));
	endtask

	task automatic check_reply(input ssp21_pkg::ssp21_function_t got_fn,
		input ssp21_pkg::ssp21_function_t exp_fn, input ssp21_pkg::ssp21_error_t got_err,
		input ssp21_pkg::ssp21_error_t exp_err, input bit with_err);
		if (got_fn !== exp_fn)
			fail_run($sformatf("reply function %s expected %s", got_fn.name(), exp_fn.name()));
		if (with_err && got_err !== exp_err)
			fail_run($sformatf("error code %s expected %s", got_err.name(), exp_err.name()));
	endtask

	task automatic check_csr(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("register %s read 0x%0h expected 0x%0h", what, got, exp));
	endtask

	///////////////////////////////////////////////////////////////////////
	// Reference model of the parser rules

	// Returns 1 when a reply is due, with its kind, code and deciding word
	function automatic bit expect_reply(input logic [15:0] dst_port, input bit end_drop,
		input ssp21_pkg::ssp21_handshake_mode_t mode, output bit is_ack,
		output ssp21_pkg::ssp21_error_t code, output int decide_idx);
		int h;
		int nbytes;
		logic [7:0] eph;
		logic [31:0] w;
		is_ack = 1'b0;
		code = ssp21_pkg::BAD_MESSAGE_FORMAT;
		decide_idx = fr_words.size();
		h = 0;
		nbytes = 0;
		eph = 8'h00;
		if (dst_port != ssp21_pkg::SSP21_SERVER_PORT)
			return 1'b0;
		for (int i = 0; i < fr_words.size(); i++) begin
			w = fr_words[i];
			// Nonce bytes are counted and trailing words do not matter
			if (h == 4) begin
				if (nbytes < 32)
					nbytes += int'(fr_bytes[i]);
				continue;
			end
			decide_idx = i;
			if (fr_bytes[i] != 3'd4)
				return 1'b1;
			case (h)
				0: begin
					if (w[31:24] != ssp21_pkg::REQUEST_HANDSHAKE_BEGIN)
						return 1'b1;
					eph = w[7:0];
				end
				1: begin
					code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_HASH;
					if (w[31:24] != ssp21_pkg::SSP21_HASH_SHA256)
						return 1'b1;
					code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_KDF;
					if (w[23:16] != ssp21_pkg::SSP21_KDF_HKDF_SHA256)
						return 1'b1;
					code = ssp21_pkg::UNSUPPORTED_NONCE_MODE;
					if (w[15:8] != ssp21_pkg::SSP21_NONCE_INCREMENT_LAST_RX)
						return 1'b1;
				end
				3: begin
					code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_MODE;
					if (w[15:8] != mode)
						return 1'b1;
					code = ssp21_pkg::UNSUPPORTED_HANDSHAKE_EPHEMERAL;
					if (eph != ssp21_pkg::NONCE)
						return 1'b1;
					code = ssp21_pkg::BAD_MESSAGE_FORMAT;
					if (w[7:0] != ssp21_pkg::SSP21_NONCE_BYTES)
						return 1'b1;
				end
				default: ;
			endcase
			h++;
		end
		// Decided by the commit or drop at the end
		code = ssp21_pkg::BAD_MESSAGE_FORMAT;
		decide_idx = fr_words.size();
		is_ack = (h == 4) && (nbytes >= 32) && !end_drop;
		return 1'b1;
	endfunction

	///////////////////////////////////////////////////////////////////////
	// Frame building and driving

	task automatic make_request(input logic [7:0] fn, input logic [7:0] hash,
		input logic [7:0] kdf, input logic [7:0] nmode, input logic [7:0] eph,
		input logic [7:0] mode, input logic [7:0] nlen, input bit split);
		int left;
		int n;
		fr_words.delete();
		fr_bytes.delete();
		rng = xorshift(rng);
		fr_words.push_back({fn, 16'h0000, eph});
		fr_words.push_back({hash, kdf, nmode, 8'h00});
		fr_words.push_back({rng[15:0], 16'h0000});
		fr_words.push_back({16'h0000, mode, nlen});
		repeat (4)
			fr_bytes.push_back(3'd4);
		// Nonce optionally cut into partial words
		left = 32;
		while (left > 0) begin
			rng = xorshift(rng);
			n = split ? int'(rng[1:0]) + 1 : 4;
			if (n > left)
				n = left;
			fr_words.push_back(rng);
			fr_bytes.push_back(3'(n));
			left -= n;
		end
	endtask

	task automatic make_valid(input ssp21_pkg::ssp21_handshake_mode_t mode, input bit split);
		make_request(ssp21_pkg::REQUEST_HANDSHAKE_BEGIN, 8'h00, 8'h00, 8'h00,
			ssp21_pkg::NONCE, mode, ssp21_pkg::SSP21_NONCE_BYTES, split);
	endtask

	task automatic send_frame(input logic [15:0] dst, input bit end_drop);
		bit has;
		bit is_ack;
		ssp21_pkg::ssp21_error_t code;
		int idx;
		int target;
		has = expect_reply(dst, end_drop, tb_mode, is_ack, code, idx);
		target = replies_seen + 1;
		rng = xorshift(rng);
		@(negedge clk);
		exp_reply = has;
		exp_is_ack = is_ack;
		exp_err = code;
		// Start edge and one edge per word come before the 2 cycles to tx_start
		exp_cycle = cyc + 1 + 1 + idx + 2;
		exp_ip = rng;
		exp_port = rng[31:16] ^ rng[15:0];
		exp_max_nonce = fr_words[2][31:16];
		if (has && is_ack)
			tally_ack++;
		else if (has) begin
			tally_err++;
			tally_last = code;
		end
		rx_start = 1'b1;
		rx_src_ip = exp_ip;
		rx_src_port = exp_port;
		rx_dst_port = dst;
		foreach (fr_words[i]) begin
			@(negedge clk);
			rx_start = 1'b0;
			rx_data_valid = 1'b1;
			rx_data = fr_words[i];
			rx_bytes_valid = fr_bytes[i];
		end
		@(negedge clk);
		rx_data_valid = 1'b0;
		rx_commit = !end_drop;
		rx_drop = end_drop;
		@(negedge clk);
		rx_commit = 1'b0;
		rx_drop = 1'b0;
		if (has) begin
			while (replies_seen < target)
				@(negedge clk);
		end else begin
			repeat (10)
				@(negedge clk);
		end
	endtask

	///////////////////////////////////////////////////////////////////////
	// AXI4-Lite master

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		bit aw_go;
		bit w_go;
		aw_go = 1'b0;
		w_go = 1'b0;
		@(negedge clk);
		s_axil_awaddr = addr;
		s_axil_awvalid = 1'b1;
		s_axil_wdata = data;
		s_axil_wstrb = 4'hF;
		s_axil_wvalid = 1'b1;
		s_axil_bready = 1'b1;
		// Ready seen at a falling edge means the beat goes at the next rising one
		while (s_axil_awvalid || s_axil_wvalid) begin
			@(negedge clk);
			if (aw_go)
				s_axil_awvalid = 1'b0;
			if (w_go)
				s_axil_wvalid = 1'b0;
			aw_go = s_axil_awvalid && s_axil_awready;
			w_go = s_axil_wvalid && s_axil_wready;
		end
		while (!s_axil_bvalid)
			@(negedge clk);
		resp = s_axil_bresp;
		@(negedge clk);
		s_axil_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(negedge clk);
		s_axil_araddr = addr;
		s_axil_arvalid = 1'b1;
		s_axil_rready = 1'b1;
		while (!s_axil_arready)
			@(negedge clk);
		@(negedge clk);
		s_axil_arvalid = 1'b0;
		while (!s_axil_rvalid)
			@(negedge clk);
		data = s_axil_rdata;
		resp = s_axil_rresp;
		@(negedge clk);
		s_axil_rready = 1'b0;
	endtask

	///////////////////////////////////////////////////////////////////////
	// Reply monitor and compare

	always @(negedge clk) begin
		if (rst_n) begin
			// Replies are never abandoned
			check_value("tx_drop", tx_drop, 1'b0);
			if (tx_start) begin
				if (!exp_reply)
					fail_run("reply sent for a frame that needs none");
				check_value("tx_start cycle", cyc, exp_cycle);
				check_value("tx_dst_ip", tx_dst_ip, exp_ip);
				check_value("tx_dst_port", tx_dst_port, exp_port);
				check_value("tx_src_port", tx_src_port, ssp21_pkg::SSP21_SERVER_PORT);
				check_value("tx_payload_len", tx_payload_len,
					exp_is_ack ? ssp21_pkg::ACK_REPLY_LEN : ssp21_pkg::ERROR_REPLY_LEN);
			end
			if (tx_data_valid) begin
				if (exp_is_ack) begin
					check_reply(ssp21_pkg::ssp21_function_t'(tx_data[31:24]),
						ssp21_pkg::REPLY_HANDSHAKE_BEGIN, exp_err, exp_err, 1'b0);
					check_value("ack ephemeral", tx_data[23:16], ssp21_pkg::NONCE);
					check_value("ack max nonce", tx_data[15:0], exp_max_nonce);
					check_value("ack bytes", tx_bytes_valid, 3'd4);
				end else begin
					check_reply(ssp21_pkg::ssp21_function_t'(tx_data[31:24]),
						ssp21_pkg::REPLY_HANDSHAKE_ERROR,
						ssp21_pkg::ssp21_error_t'(tx_data[23:16]), exp_err, 1'b1);
					check_value("error bytes", tx_bytes_valid, 3'd2);
				end
			end
			if (tx_commit)
				replies_seen++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk);
		$display("Watchdog expired before the tests completed");
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	///////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic [1:0] resp;
		rst_n = 1'b0;
		rx_start = 1'b0;
		rx_src_ip = 32'd0;
		rx_src_port = 16'd0;
		rx_dst_port = 16'd0;
		rx_data_valid = 1'b0;
		rx_data = 32'd0;
		rx_bytes_valid = 3'd0;
		rx_commit = 1'b0;
		rx_drop = 1'b0;
		s_axil_awaddr = 4'd0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = 32'd0;
		s_axil_wstrb = 4'd0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b0;
		s_axil_araddr = 4'd0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;
		exp_reply = 1'b0;
		exp_is_ack = 1'b0;
		exp_err = ssp21_pkg::BAD_MESSAGE_FORMAT;
		replies_seen = 0;
		tally_ack = 0;
		tally_err = 0;
		tally_last = ssp21_pkg::BAD_MESSAGE_FORMAT;
		tb_mode = ssp21_pkg::SHARED_SECRET;
		rng = 32'he50b7db3;
		cyc = 0;
		errors = 0;
		repeat (5)
			@(negedge clk);
		rst_n = 1'b1;

		// Valid requests, whole and split nonce
		make_valid(ssp21_pkg::SHARED_SECRET, 1'b0);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_valid(ssp21_pkg::SHARED_SECRET, 1'b1);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_valid(ssp21_pkg::SHARED_SECRET, 1'b1);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);

		// Crypto spec and ephemeral rejections
		make_request(8'h00, 8'h01, 8'h00, 8'h00, ssp21_pkg::NONCE, 8'h00, 8'd32, 1'b0);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_request(8'h00, 8'h00, 8'h03, 8'h00, ssp21_pkg::NONCE, 8'h00, 8'd32, 1'b0);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_request(8'h00, 8'h00, 8'h00, 8'h02, ssp21_pkg::NONCE, 8'h00, 8'd32, 1'b0);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_request(8'h00, 8'h00, 8'h00, 8'h00, ssp21_pkg::X25519, 8'h00, 8'd32, 1'b0);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_request(8'h00, 8'h00, 8'h00, 8'h00, ssp21_pkg::NONCE, 8'h00, 8'd16, 1'b1);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);

		// Malformed frames and a foreign port
		make_valid(ssp21_pkg::SHARED_SECRET, 1'b0);
		fr_bytes[1] = 3'd3;
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_request(8'h05, 8'h00, 8'h00, 8'h00, ssp21_pkg::NONCE, 8'h00, 8'd32, 1'b0);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_valid(ssp21_pkg::SHARED_SECRET, 1'b1);
		void'(fr_words.pop_back());
		void'(fr_bytes.pop_back());
		void'(fr_words.pop_back());
		void'(fr_bytes.pop_back());
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b1);
		make_valid(ssp21_pkg::SHARED_SECRET, 1'b0);
		send_frame(16'd1234, 1'b0);

		// Reconfigured handshake mode
		axil_write(ssp21_pkg::CSR_MODE, {24'd0, ssp21_pkg::PRESHARED_PUBLIC}, resp);
		check_value("MODE write response", resp, ssp21_pkg::AXI_RESP_OKAY);
		tb_mode = ssp21_pkg::PRESHARED_PUBLIC;
		axil_read(ssp21_pkg::CSR_MODE, rd, resp);
		check_csr("MODE", rd, {24'd0, ssp21_pkg::PRESHARED_PUBLIC});
		make_valid(ssp21_pkg::SHARED_SECRET, 1'b0);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);
		make_valid(ssp21_pkg::PRESHARED_PUBLIC, 1'b1);
		send_frame(ssp21_pkg::SSP21_SERVER_PORT, 1'b0);

		// Status registers against the tally
		axil_read(ssp21_pkg::CSR_HANDSHAKE_COUNT, rd, resp);
		check_csr("HANDSHAKE_COUNT", rd, tally_ack);
		axil_read(ssp21_pkg::CSR_ERROR_COUNT, rd, resp);
		check_csr("ERROR_COUNT", rd, tally_err);
		axil_read(ssp21_pkg::CSR_LAST_ERROR, rd, resp);
		check_csr("LAST_ERROR", rd, {24'd0, tally_last});
		axil_read(4'h2, rd, resp);
		check_value("unmapped read response", resp, ssp21_pkg::AXI_RESP_SLVERR);

		repeat (5)
			@(negedge clk);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
source/ssp21_pkg.sv
source/ssp21_rx_parser.sv
source/ssp21_tx_responder.sv
source/ssp21_csr.sv
source/ssp21_udp_server.sv
verif/ssp21_udp_server_properties.sv
verif/tb_ssp21_udp_server.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_ssp21_udp_server -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
